// File: logic/ep_csr_pkg.sv
// Endpoint CSR shared widths, register index map, reset values and identity constants
`default_nettype none

package ep_csr_pkg;

    // ----------------------------------------
    // Data path and index widths
    // ----------------------------------------
    localparam int csr_data_w = 32;
    localparam int csr_addr_w = 7;

    typedef logic [csr_data_w-1:0] csr_data_t;
    typedef logic [csr_addr_w-1:0] csr_addr_t;

    // Word-addressed register map
    typedef enum logic [csr_addr_w-1:0] {
        CSR_IDENT     = 7'd0,   // Family, type, version, init reset
        CSR_MWR_START = 7'd1,   // Write only
        CSR_QUEUE     = 7'd2,   // Buffer address queue
        CSR_DAC       = 7'd3,
        CSR_CFG1_HI   = 7'd4,   // Config 1 upper field
        CSR_CFG2      = 7'd5,
        CSR_MWR_COUNT = 7'd6,   // Packets per buffer
        CSR_FRAME_LEN = 7'd7,   // Config 1 lower field
        CSR_USER_ID   = 7'd8,
        CSR_TEST      = 7'd9
    } csr_idx_e;

    // Config 1 split, upper field on top
    localparam int cfg1_hi_w   = 19;
    localparam int frame_len_w = 13;

    // ----------------------------------------
    // Constants and reset values
    // ----------------------------------------
    localparam logic [7:0] version_number = 8'h16;
    localparam csr_data_t  test_word      = 32'hABD0_FFCE;

    localparam csr_data_t dac_reset = 32'h8080_8080;   // All DACs at mid scale

    localparam logic [cfg1_hi_w-1:0]   cfg1_hi_reset   = 19'h0_0100;
    localparam logic [frame_len_w-1:0] frame_len_reset = '1;   // Longest frame
    localparam csr_data_t cfg1_reset = {cfg1_hi_reset, frame_len_reset};

    localparam csr_data_t cfg2_reset      = 32'h0002_0000;
    localparam csr_data_t mwr_count_reset = 32'd32768;   // 4 MB of 128 byte packets

endpackage

`default_nettype wire

// File: logic/ep_ctrl_regs.sv
// Writable control and configuration registers of the endpoint CSR block
`timescale 1ns/1ps
`default_nettype none

module ep_ctrl_regs
    import ep_csr_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire csr_addr_t  a_i,
    input  wire             wr_en_i,
    input  wire csr_data_t  wr_d_i,

    output logic            init_rst_o,
    output logic            mwr_start_o,
    output csr_data_t       dac_data_o,
    output csr_data_t       config_reg_1_o,
    output csr_data_t       config_reg_2_o,
    output csr_data_t       mwr_count_o
);

    csr_idx_e wr_idx;

    // Config 1 kept as two fields, joined on the output
    logic [cfg1_hi_w-1:0]   cfg1_hi_q;
    logic [frame_len_w-1:0] frame_len_q;

    assign wr_idx         = csr_idx_e'(a_i);
    assign config_reg_1_o = {cfg1_hi_q, frame_len_q};

    // ----------------------------------------
    // Control bits
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o  <= 1'b0;
            mwr_start_o <= 1'b0;
        end else if (wr_en_i) begin
            case (wr_idx)
                CSR_IDENT:     init_rst_o  <= wr_d_i[0];   // Initiator reset
                CSR_MWR_START: mwr_start_o <= wr_d_i[0];   // Start DMA writes
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Setting and configuration words
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac_data_o     <= dac_reset;
            config_reg_2_o <= cfg2_reset;
            mwr_count_o    <= mwr_count_reset;
        end else if (wr_en_i) begin
            case (wr_idx)
                CSR_DAC:       dac_data_o     <= wr_d_i;
                CSR_CFG2:      config_reg_2_o <= wr_d_i;
                CSR_MWR_COUNT: mwr_count_o    <= wr_d_i;   // Packets per buffer
                default: ;
            endcase
        end
    end

    // Each config 1 field only takes its own width from the low data bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg1_hi_q   <= cfg1_hi_reset;
            frame_len_q <= frame_len_reset;
        end else if (wr_en_i) begin
            case (wr_idx)
                CSR_CFG1_HI: begin
                    cfg1_hi_q <= wr_d_i[cfg1_hi_w-1:0];
                end
                CSR_FRAME_LEN: begin
                    frame_len_q <= wr_d_i[frame_len_w-1:0];
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Config 1 moves only after a write to one of its two indices
    property p_cfg1_write_only;
        @(posedge clk) disable iff (!rst_n)
            ($past(rst_n) && (config_reg_1_o != $past(config_reg_1_o)))
            |-> $past(wr_en_i && ((a_i == CSR_CFG1_HI) || (a_i == CSR_FRAME_LEN)));
    endproperty

    a_cfg1_write_only : assert property (p_cfg1_write_only)
        else $error("config_reg_1_o changed without a write to index 4 or 7");

endmodule

`default_nettype wire

// File: logic/ep_queue_port.sv
// Buffer address queue port with write and read strobes for the queue
`timescale 1ns/1ps
`default_nettype none

module ep_queue_port
    import ep_csr_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire csr_addr_t  a_i,
    input  wire             wr_en_i,
    input  wire csr_data_t  wr_d_i,

    output csr_data_t       mwr_addr_o,         // Address pushed to the queue
    output logic            addr_wr_enable_o,   // Push strobe
    output logic            addr_rd_enable_o    // Pop strobe
);

    logic queue_sel;

    assign queue_sel = (a_i == CSR_QUEUE);

    // ----------------------------------------
    // Queue register and strobes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mwr_addr_o       <= '0;
            addr_wr_enable_o <= 1'b0;
            addr_rd_enable_o <= 1'b0;
        end else if (queue_sel) begin
            if (wr_en_i)
                mwr_addr_o <= wr_d_i;
            // Level strobes, held for as long as index 2 stays on the port
            addr_wr_enable_o <= wr_en_i;
            addr_rd_enable_o <= !wr_en_i;
        end else begin
            addr_wr_enable_o <= 1'b0;
            addr_rd_enable_o <= 1'b0;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_strobe_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
            !(addr_wr_enable_o && addr_rd_enable_o)
    ) else $error("Queue push and pop strobes high together");

    // Queue side must never see a strobe for another register
    a_strobe_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
            !queue_sel |=> (!addr_wr_enable_o && !addr_rd_enable_o)
    ) else $error("Queue strobe raised for an index other than 2");

endmodule

`default_nettype wire

// File: logic/ep_readback_mux.sv
// Registered read-back selection of the CSR words by register index
`timescale 1ns/1ps
`default_nettype none

module ep_readback_mux
    import ep_csr_pkg::*;
#(
    parameter logic [7:0] fpga_family    = 8'h14,
    parameter logic [3:0] interface_type = 4'd2
) (
    input  wire             clk,
    input  wire             rst_n,

    input  wire csr_addr_t  a_i,
    input  wire             wr_en_i,

    // Stored words from the register bank
    input  wire             init_rst_i,
    input  wire csr_data_t  dac_data_i,
    input  wire csr_data_t  config_reg_1_i,
    input  wire csr_data_t  config_reg_2_i,
    input  wire csr_data_t  mwr_count_i,

    input  wire csr_data_t  mwr_addr_i,     // Address offered by the queue
    input  wire csr_data_t  usr_id_i,

    output csr_data_t       rd_d_o
);

    csr_idx_e  rd_idx;
    csr_data_t ident_word;
    csr_data_t cfg1_hi_word;
    csr_data_t frame_len_word;

    assign rd_idx = csr_idx_e'(a_i);

    // Family, 4 zeros, type, version, 7 zeros, init reset
    assign ident_word = {fpga_family, 4'b0000, interface_type, version_number,
                         7'b000_0000, init_rst_i};

    // Config 1 fields come back right aligned
    assign cfg1_hi_word   = {{(csr_data_w-cfg1_hi_w){1'b0}},
                             config_reg_1_i[csr_data_w-1 -: cfg1_hi_w]};
    assign frame_len_word = {{(csr_data_w-frame_len_w){1'b0}},
                             config_reg_1_i[frame_len_w-1:0]};

    // ----------------------------------------
    // Read data register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_d_o <= '0;
        end else begin
            case (rd_idx)
                CSR_IDENT:     rd_d_o <= ident_word;
                CSR_QUEUE: begin
                    if (!wr_en_i)
                        rd_d_o <= mwr_addr_i;   // Pop side only
                end
                CSR_DAC:       rd_d_o <= dac_data_i;
                CSR_CFG1_HI:   rd_d_o <= cfg1_hi_word;
                CSR_CFG2:      rd_d_o <= config_reg_2_i;
                CSR_MWR_COUNT: rd_d_o <= mwr_count_i;
                CSR_FRAME_LEN: rd_d_o <= frame_len_word;
                CSR_USER_ID:   rd_d_o <= usr_id_i;
                CSR_TEST:      rd_d_o <= test_word;
                default: ;                      // Write-only or unmapped, hold
            endcase
        end
    end

    // Start bit is write only, so the host sees the last read word
    a_hold_on_start : assert property (
        @(posedge clk) disable iff (!rst_n)
            (a_i == CSR_MWR_START) |=> (rd_d_o == $past(rd_d_o))
    ) else $error("rd_d_o changed after an access to index 1");

endmodule

`default_nettype wire

// File: logic/ep_csr_top.sv
// Endpoint control and status register block with host register port
`timescale 1ns/1ps
`default_nettype none

module ep_csr_top
    import ep_csr_pkg::*;
#(
    parameter logic [7:0] fpga_family    = 8'h14,
    parameter logic [3:0] interface_type = 4'd2
) (
    input  wire             clk,
    input  wire             rst_n,

    // Host register port
    input  wire csr_addr_t  a_i,
    input  wire             wr_en_i,
    input  wire csr_data_t  wr_d_i,
    output csr_data_t       rd_d_o,

    // Buffer queue
    input  wire csr_data_t  mwr_addr_i,
    output csr_data_t       mwr_addr_o,
    output logic            addr_wr_enable_o,
    output logic            addr_rd_enable_o,

    input  wire csr_data_t  usr_id_i,     // Device user ID word

    // Control outputs
    output logic            init_rst_o,
    output logic            mwr_start_o,
    output csr_data_t       dac_data_o,
    output csr_data_t       config_reg_1_o,
    output csr_data_t       config_reg_2_o,
    output csr_data_t       mwr_count_o
);

    ep_ctrl_regs u_ctrl_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .a_i            (a_i),
        .wr_en_i        (wr_en_i),
        .wr_d_i         (wr_d_i),
        .init_rst_o     (init_rst_o),
        .mwr_start_o    (mwr_start_o),
        .dac_data_o     (dac_data_o),
        .config_reg_1_o (config_reg_1_o),
        .config_reg_2_o (config_reg_2_o),
        .mwr_count_o    (mwr_count_o)
    );

    ep_queue_port u_queue_port (
        .clk              (clk),
        .rst_n            (rst_n),
        .a_i              (a_i),
        .wr_en_i          (wr_en_i),
        .wr_d_i           (wr_d_i),
        .mwr_addr_o       (mwr_addr_o),
        .addr_wr_enable_o (addr_wr_enable_o),
        .addr_rd_enable_o (addr_rd_enable_o)
    );

    // Read path sees the stored words straight from the bank
    ep_readback_mux #(
        .fpga_family    (fpga_family),
        .interface_type (interface_type)
    ) u_readback_mux (
        .clk            (clk),
        .rst_n          (rst_n),
        .a_i            (a_i),
        .wr_en_i        (wr_en_i),
        .init_rst_i     (init_rst_o),
        .dac_data_i     (dac_data_o),
        .config_reg_1_i (config_reg_1_o),
        .config_reg_2_i (config_reg_2_o),
        .mwr_count_i    (mwr_count_o),
        .mwr_addr_i     (mwr_addr_i),
        .usr_id_i       (usr_id_i),
        .rd_d_o         (rd_d_o)
    );

endmodule

`default_nettype wire

// File: bench/ep_csr_checker.sv
// Scoreboard for the endpoint CSR block, models the registers and compares DUT outputs
`timescale 1ns/1ps
`default_nettype none

module ep_csr_checker
    import ep_csr_pkg::*;
#(
    parameter int         name_w         = 96,
    parameter logic [7:0] fpga_family    = 8'h14,
    parameter logic [3:0] interface_type = 4'd2
) (
    input  wire              clk,
    input  wire              rst_n,
    // Row being applied
    input  wire [name_w-1:0] name_i,
    input  wire              chk_rd_i,     // Row expects a read result
    input  wire csr_addr_t   a_i,
    input  wire              wr_en_i,
    input  wire csr_data_t   wr_d_i,
    input  wire csr_data_t   mwr_addr_i,
    input  wire csr_data_t   usr_id_i,
    // DUT outputs
    input  wire csr_data_t   rd_d_i,
    input  wire              init_rst_i,
    input  wire              mwr_start_i,
    input  wire csr_data_t   mwr_addr_q_i,
    input  wire              addr_wr_enable_i,
    input  wire              addr_rd_enable_i,
    input  wire csr_data_t   dac_data_i,
    input  wire csr_data_t   config_reg_1_i,
    input  wire csr_data_t   config_reg_2_i,
    input  wire csr_data_t   mwr_count_i,
    output int               err_cnt_o
);

    logic              m_init, m_start, exp_wr_stb, exp_rd_stb, armed, chk_rd_q;
    csr_data_t         m_dac, m_cfg1, m_cfg2, m_count, m_addr, exp_rd;
    logic [name_w-1:0] name_q;
    int                err_cnt = 0;

    assign err_cnt_o = err_cnt;

    // ----------------------------------------
    // Register model, updated on each edge
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            m_init = 1'b0;
            m_start = 1'b0;
            m_addr = 32'h0;
            m_dac = 32'h8080_8080;
            m_cfg1 = 32'h0020_1FFF;     // 19'h100 over a full frame length
            m_cfg2 = 32'h0002_0000;
            m_count = 32'd32768;
            exp_rd = 32'h0;
            exp_wr_stb = 1'b0;
            exp_rd_stb = 1'b0;
            armed = 1'b0;
        end else begin
            name_q = name_i;
            chk_rd_q = chk_rd_i;
            // Read side sees the words as they stood before this edge
            case (a_i)
                7'd0: exp_rd = {fpga_family, 4'h0, interface_type, 8'h16, 7'h00, m_init};
                7'd2: if (!wr_en_i) exp_rd = mwr_addr_i;
                7'd3: exp_rd = m_dac;
                7'd4: exp_rd = {13'h0, m_cfg1[31:13]};
                7'd5: exp_rd = m_cfg2;
                7'd6: exp_rd = m_count;
                7'd7: exp_rd = {19'h0, m_cfg1[12:0]};
                7'd8: exp_rd = usr_id_i;
                7'd9: exp_rd = 32'hABD0_FFCE;
                default: ;              // Hold
            endcase
            exp_wr_stb = (a_i == 7'd2) && wr_en_i;
            exp_rd_stb = (a_i == 7'd2) && !wr_en_i;
            if (wr_en_i) begin
                case (a_i)
                    7'd0: m_init = wr_d_i[0];
                    7'd1: m_start = wr_d_i[0];
                    7'd2: m_addr = wr_d_i;
                    7'd3: m_dac = wr_d_i;
                    7'd4: m_cfg1[31:13] = wr_d_i[18:0];
                    7'd5: m_cfg2 = wr_d_i;
                    7'd6: m_count = wr_d_i;
                    7'd7: m_cfg1[12:0] = wr_d_i[12:0];
                    default: ;
                endcase
            end
            armed = 1'b1;
        end
    end

    task automatic check_word(input string what, input csr_data_t exp, input csr_data_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("Fail %0s %0s expected %h actual %h", name_q, what, exp, act);
        end
    endtask

    // Outputs are stable mid cycle
    always @(negedge clk) begin
        if (armed) begin
            if (chk_rd_q)
                check_word("rd_d_o", exp_rd, rd_d_i);
            check_word("init_rst_o", {31'h0, m_init}, {31'h0, init_rst_i});
            check_word("mwr_start_o", {31'h0, m_start}, {31'h0, mwr_start_i});
            check_word("mwr_addr_o", m_addr, mwr_addr_q_i);
            check_word("addr_wr_enable_o", {31'h0, exp_wr_stb}, {31'h0, addr_wr_enable_i});
            check_word("addr_rd_enable_o", {31'h0, exp_rd_stb}, {31'h0, addr_rd_enable_i});
            check_word("dac_data_o", m_dac, dac_data_i);
            check_word("config_reg_1_o", m_cfg1, config_reg_1_i);
            check_word("config_reg_2_o", m_cfg2, config_reg_2_i);
            check_word("mwr_count_o", m_count, mwr_count_i);
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_ep_csr.sv
// Testbench for the endpoint CSR block applying a stimulus table one row per cycle
`timescale 1ns/1ps
`default_nettype none

module tb_ep_csr
    import ep_csr_pkg::*;
();

    localparam int         half_period    = 10;
    localparam int         reset_cycles   = 10;
    localparam int         max_rows       = 64;
    localparam int         name_w         = 96;    // 12 characters
    localparam logic [7:0] fpga_family    = 8'h14;
    localparam logic [3:0] interface_type = 4'd2;

    // Row flags
    localparam logic rd_op = 1'b0;
    localparam logic wr_op = 1'b1;
    localparam logic fixed = 1'b0;
    localparam logic rnd   = 1'b1;
    localparam logic chk   = 1'b1;

    localparam csr_data_t q_a = 32'h0BAD_F00D;   // Queue head address
    localparam csr_data_t q_b = 32'h1000_2040;
    localparam csr_data_t uid = 32'h5EED_1D08;

    logic              clk = 1'b0;
    logic              rst_n, wr_en, cur_chk;
    csr_addr_t         a;
    csr_data_t         wr_d, mwr_addr, usr_id;
    logic [name_w-1:0] cur_name;
    logic              init_rst, mwr_start, addr_wr_enable, addr_rd_enable;
    csr_data_t         rd_d, mwr_addr_q, dac_data, config_reg_1, config_reg_2, mwr_count;
    int                err_cnt;
    int                cycle_cnt = 0;
    int                timeout_limit;

    // Stimulus table
    logic [name_w-1:0] t_name [max_rows];
    csr_addr_t         t_idx  [max_rows];
    csr_data_t         t_data [max_rows];
    csr_data_t         t_mwr  [max_rows];
    csr_data_t         t_uid  [max_rows];
    logic              t_wr   [max_rows];
    logic              t_rnd  [max_rows];
    logic              t_chk  [max_rows];
    int                row_count = 0;

    always #(half_period) clk = ~clk;

    ep_csr_top #(
        .fpga_family(fpga_family), .interface_type(interface_type)
    ) u_dut (
        .clk(clk), .rst_n(rst_n), .a_i(a), .wr_en_i(wr_en), .wr_d_i(wr_d), .rd_d_o(rd_d),
        .mwr_addr_i(mwr_addr), .mwr_addr_o(mwr_addr_q),
        .addr_wr_enable_o(addr_wr_enable), .addr_rd_enable_o(addr_rd_enable),
        .usr_id_i(usr_id), .init_rst_o(init_rst), .mwr_start_o(mwr_start),
        .dac_data_o(dac_data), .config_reg_1_o(config_reg_1),
        .config_reg_2_o(config_reg_2), .mwr_count_o(mwr_count)
    );

    ep_csr_checker #(
        .name_w(name_w), .fpga_family(fpga_family), .interface_type(interface_type)
    ) u_checker (
        .clk(clk), .rst_n(rst_n), .name_i(cur_name), .chk_rd_i(cur_chk),
        .a_i(a), .wr_en_i(wr_en), .wr_d_i(wr_d), .mwr_addr_i(mwr_addr), .usr_id_i(usr_id),
        .rd_d_i(rd_d), .init_rst_i(init_rst), .mwr_start_i(mwr_start),
        .mwr_addr_q_i(mwr_addr_q), .addr_wr_enable_i(addr_wr_enable),
        .addr_rd_enable_i(addr_rd_enable), .dac_data_i(dac_data),
        .config_reg_1_i(config_reg_1), .config_reg_2_i(config_reg_2),
        .mwr_count_i(mwr_count), .err_cnt_o(err_cnt)
    );

    task automatic add_row(input logic [name_w-1:0] name, input int idx, input logic wr,
                           input csr_data_t data, input logic rand_data,
                           input csr_data_t mwr, input csr_data_t id, input logic chk_rd);
        t_name[row_count] = name;
        t_idx[row_count]  = idx[csr_addr_w-1:0];
        t_wr[row_count]   = wr;
        t_data[row_count] = data;
        t_rnd[row_count]  = rand_data;
        t_mwr[row_count]  = mwr;
        t_uid[row_count]  = id;
        t_chk[row_count]  = chk_rd;
        row_count++;
    endtask

    task automatic build_table();
        // Reset values
        add_row("rst_ident", 0, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rst_dac", 3, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rst_cfg1_hi", 4, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rst_cfg2", 5, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rst_count", 6, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rst_frame", 7, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("user_id", 8, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("test_word", 9, rd_op, 32'h0, fixed, q_a, uid, chk);
        // Plain words and control bits
        add_row("wr_dac", 3, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("rd_dac", 3, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("wr_cfg2", 5, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("rd_cfg2", 5, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("wr_count", 6, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("rd_count", 6, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("set_init", 0, wr_op, 32'h0000_0001, fixed, q_a, uid, chk);
        add_row("rd_ident", 0, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("set_start", 1, wr_op, 32'hFFFF_FFFF, fixed, q_a, uid, chk);
        add_row("clr_init", 0, wr_op, 32'hFFFF_FFFE, fixed, q_a, uid, chk);
        // Config 1 fields
        add_row("wr_cfg1_hi", 4, wr_op, 32'hFFFA_5A5A, fixed, q_a, uid, chk);
        add_row("rd_cfg1_hi", 4, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rd_frame_a", 7, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("wr_frame", 7, wr_op, 32'hFFFF_E123, fixed, q_a, uid, chk);
        add_row("rd_frame_b", 7, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rd_cfg1_hi_b", 4, rd_op, 32'h0, fixed, q_a, uid, chk);
        // Queue port
        add_row("wr_queue", 2, wr_op, 32'hC0DE_0040, fixed, q_a, uid, chk);
        add_row("rd_queue_a", 2, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rd_queue_b", 2, rd_op, 32'h0, fixed, q_b, uid, chk);
        add_row("wr_queue_r", 2, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("after_queue", 3, rd_op, 32'h0, fixed, q_b, uid, chk);
        // Hold cases
        add_row("rd_test_b", 9, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rd_start", 1, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("unmapped_10", 10, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("unmapped_64", 64, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("unmapped_127", 127, rd_op, 32'h0, fixed, q_a, uid, chk);
        // Read during a write to the same index
        add_row("rw_dac", 3, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("rd_dac_b", 3, rd_op, 32'h0, fixed, q_a, uid, chk);
        add_row("rw_cfg2", 5, wr_op, 32'h0, rnd, q_a, uid, chk);
        add_row("rd_cfg2_b", 5, rd_op, 32'h0, fixed, q_a, 32'h0, chk);
    endtask

    // Run limit from table length and reset
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd370));
        build_table();
        timeout_limit = row_count + reset_cycles + 50;
        rst_n = 1'b0;
        a = '0;
        wr_en = 1'b0;
        wr_d = '0;
        mwr_addr = '0;
        usr_id = '0;
        cur_name = '0;
        cur_chk = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < row_count; i++) begin
            if (i > 0)
                @(negedge clk);
            cur_name = t_name[i];
            cur_chk  = t_chk[i];
            a        = t_idx[i];
            wr_en    = t_wr[i];
            wr_d     = t_rnd[i] ? $urandom() : t_data[i];
            mwr_addr = t_mwr[i];
            usr_id   = t_uid[i];
        end
        @(negedge clk);
        a = 7'd1;           // Idle on the write-only index
        wr_en = 1'b0;
        cur_chk = 1'b0;
        @(posedge clk);
        $display("Summary: %0d errors over %0d rows", err_cnt, row_count);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/ep_csr_pkg.sv
logic/ep_ctrl_regs.sv
logic/ep_queue_port.sv
logic/ep_readback_mux.sv
logic/ep_csr_top.sv
bench/ep_csr_checker.sv
bench/tb_ep_csr.sv

// File: run.sh
#!/bin/sh
# Compile and run the endpoint CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_ep_csr \
    -o tb_ep_csr > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_ep_csr > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
